// ==== verilog/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int unsigned data_width = 32;
  localparam int unsigned op_width   = 3;
  localparam int unsigned lane_count = 4;

  // --------------------------------------------------
  // Operation codes
  // --------------------------------------------------
  localparam logic [op_width-1:0] op_byte   = 3'd0;
  localparam logic [op_width-1:0] op_half   = 3'd1;
  localparam logic [op_width-1:0] op_word   = 3'd2;
  localparam logic [op_width-1:0] op_byte_u = 3'd4;  // Bit 2 set means zero extend
  localparam logic [op_width-1:0] op_half_u = 3'd5;

  // Access lengths in bytes
  localparam logic [2:0] len_byte = 3'd1;
  localparam logic [2:0] len_half = 3'd2;
  localparam logic [2:0] len_word = 3'd4;

  function automatic logic [2:0] op_len(input logic [op_width-1:0] op);
    logic [2:0] len;
    case (op)
      op_byte, op_byte_u: len = len_byte;
      op_half, op_half_u: len = len_half;
      op_word:            len = len_word;
      default:            len = len_word;
    endcase
    return len;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/lsu_cmd_split.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu_cmd_split (
  input  logic                           clk,
  input  logic                           rest,
  input  logic [lsu_pkg::data_width-1:0] addr,
  input  logic [lsu_pkg::data_width-1:0] wdata,
  input  logic [lsu_pkg::op_width-1:0]   op,
  input  logic                           read,
  input  logic                           write,
  input  logic                           avl_request_ready,
  output logic                           split,
  output logic                           cmd_done,
  output logic [lsu_pkg::data_width-1:0] avl_address,
  output logic                           avl_read,
  output logic                           avl_write,
  output logic [lsu_pkg::lane_count-1:0] avl_byte_en,
  output logic [lsu_pkg::data_width-1:0] avl_write_data
);

  logic [2:0]                             len;
  logic [1:0]                             offset;
  logic [lsu_pkg::lane_count-1:0]         base_be;
  logic [2*lsu_pkg::data_width-1:0]       data_wide;
  logic [2*lsu_pkg::lane_count-1:0]       be_wide;
  logic [lsu_pkg::data_width-1:0]         word_addr [2];
  logic                                   sent;
  logic                                   sel;
  logic                                   word_valid;
  logic                                   fire;

  assign len    = lsu_pkg::op_len(op);
  assign offset = addr[1:0];
  assign split  = ({1'b0, offset} + len) > lsu_pkg::len_word;  // Access runs past the word

  // --------------------------------------------------
  // Word addresses and lane placement
  // --------------------------------------------------
  assign word_addr[0] = {addr[lsu_pkg::data_width-1:2], 2'b00};
  assign word_addr[1] = word_addr[0] + lsu_pkg::data_width'(lsu_pkg::lane_count);

  always_comb begin
    case (len)
      lsu_pkg::len_byte: base_be = 4'b0001;
      lsu_pkg::len_half: base_be = 4'b0011;
      default:           base_be = 4'b1111;
    endcase
  end

  // Low half feeds the first word, high half spills into the second
  assign data_wide = {{lsu_pkg::data_width{1'b0}}, wdata} << {offset, 3'b000};
  assign be_wide   = {{lsu_pkg::lane_count{1'b0}}, base_be} << offset;

  // --------------------------------------------------
  // Command sequencing
  // --------------------------------------------------
  assign sel        = sent;                      // First word always goes first
  assign word_valid = sel ? split : 1'b1;

  assign avl_read       = read && word_valid;
  assign avl_write      = write && word_valid;
  assign avl_address    = word_addr[sel];
  assign avl_byte_en    = sel ? be_wide[2*lsu_pkg::lane_count-1:lsu_pkg::lane_count]
                              : be_wide[lsu_pkg::lane_count-1:0];
  assign avl_write_data = sel ? data_wide[2*lsu_pkg::data_width-1:lsu_pkg::data_width]
                              : data_wide[lsu_pkg::data_width-1:0];

  assign fire     = (avl_read || avl_write) && avl_request_ready;
  assign cmd_done = fire && (sel || !split);     // Last needed command accepted

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      sent <= 1'b0;
    end else begin
      if (cmd_done) begin
        sent <= 1'b0;                            // Ready for the next access at once
      end else if (fire) begin
        sent <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/lsu_rsp_merge.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu_rsp_merge (
  input  logic                           clk,
  input  logic                           rest,
  input  logic                           start,
  input  logic [1:0]                     offset,
  input  logic [lsu_pkg::op_width-1:0]   op,
  input  logic                           split,
  input  logic [lsu_pkg::data_width-1:0] avl_read_data,
  input  logic                           avl_read_data_valid,
  output logic                           load_done,
  output logic [lsu_pkg::data_width-1:0] load_data
);

  logic [1:0]                       beat_cnt;
  logic [1:0]                       beats_needed;
  logic                             last_beat;
  logic [2*lsu_pkg::data_width-1:0] asm_q;
  logic [lsu_pkg::data_width-1:0]   shifted;
  logic [2:0]                       len;
  logic                             fill;

  assign beats_needed = split ? 2'd2 : 2'd1;
  assign last_beat    = avl_read_data_valid && ((beat_cnt + 2'd1) == beats_needed);

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      beat_cnt  <= 2'd0;
      load_done <= 1'b0;
    end else begin
      load_done <= last_beat;                    // One cycle after the final beat
      if (start) begin
        beat_cnt <= 2'd0;
      end else if (avl_read_data_valid) begin
        beat_cnt <= beat_cnt + 2'd1;
      end
    end
  end

  // Low word first, the second beat fills the upper half
  always_ff @(posedge clk) begin
    if (avl_read_data_valid) begin
      if (beat_cnt == 2'd0) begin
        asm_q[lsu_pkg::data_width-1:0] <= avl_read_data;
      end else begin
        asm_q[2*lsu_pkg::data_width-1:lsu_pkg::data_width] <= avl_read_data;
      end
    end
  end

  // --------------------------------------------------
  // Alignment and extension
  // --------------------------------------------------
  assign shifted = lsu_pkg::data_width'(asm_q >> {offset, 3'b000});
  assign len     = lsu_pkg::op_len(op);

  always_comb begin
    fill = 1'b0;
    case (len)
      lsu_pkg::len_byte: begin
        fill      = shifted[7] && !op[2];
        load_data = {{(lsu_pkg::data_width-8){fill}}, shifted[7:0]};
      end
      lsu_pkg::len_half: begin
        fill      = shifted[15] && !op[2];
        load_data = {{(lsu_pkg::data_width-16){fill}}, shifted[15:0]};
      end
      default: load_data = shifted;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/lsu_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu_ctrl (
  input  logic                           clk,
  input  logic                           rest,
  input  logic                           req_valid,
  input  logic [lsu_pkg::data_width-1:0] req_addr,
  input  logic [lsu_pkg::data_width-1:0] req_wdata,
  input  logic                           req_write,
  input  logic [lsu_pkg::op_width-1:0]   req_op,
  input  logic                           rsp_ready,
  input  logic                           cmd_done,
  input  logic                           load_done,
  input  logic [lsu_pkg::data_width-1:0] load_data,
  output logic                           req_ready,
  output logic                           rsp_valid,
  output logic [lsu_pkg::data_width-1:0] rsp_rdata,
  output logic                           start,
  output logic [lsu_pkg::data_width-1:0] addr,
  output logic [lsu_pkg::data_width-1:0] wdata,
  output logic [lsu_pkg::op_width-1:0]   op,
  output logic                           read,
  output logic                           write
);

  typedef enum logic [1:0] {st_idle, st_issue, st_respond} state_t;

  state_t                         state;
  logic                           write_q;
  logic                           cmd_fin;
  logic                           load_fin;
  logic                           cmd_ok;
  logic                           load_ok;
  logic [lsu_pkg::data_width-1:0] rdata_q;

  assign req_ready = (state == st_idle);
  assign start     = req_valid && req_ready;
  assign rsp_valid = (state == st_respond);
  assign rsp_rdata = rdata_q;

  // Commands stay up until the splitter reports the last one taken
  assign read  = (state == st_issue) && !write_q && !cmd_fin;
  assign write = (state == st_issue) && write_q && !cmd_fin;

  assign cmd_ok  = cmd_fin || cmd_done;
  assign load_ok = write_q || load_fin || load_done;  // Stores need no read data

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state    <= st_idle;
      cmd_fin  <= 1'b0;
      load_fin <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state    <= st_issue;
            cmd_fin  <= 1'b0;
            load_fin <= 1'b0;
          end
        end
        st_issue: begin
          if (cmd_done) cmd_fin <= 1'b1;
          if (load_done) load_fin <= 1'b1;
          if (cmd_ok && load_ok) state <= st_respond;
        end
        st_respond: begin
          if (rsp_ready) state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      addr    <= req_addr;
      wdata   <= req_wdata;
      op      <= req_op;
      write_q <= req_write;
      rdata_q <= '0;
    end else if (load_done) begin
      rdata_q <= load_data;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/lsu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu_top (
  input  logic                           clk,
  input  logic                           rest,
  input  logic                           req_valid,
  output logic                           req_ready,
  input  logic [lsu_pkg::data_width-1:0] req_addr,
  input  logic [lsu_pkg::data_width-1:0] req_wdata,
  input  logic                           req_write,
  input  logic [lsu_pkg::op_width-1:0]   req_op,
  output logic                           rsp_valid,
  input  logic                           rsp_ready,
  output logic [lsu_pkg::data_width-1:0] rsp_rdata,
  output logic [lsu_pkg::data_width-1:0] avl_address,
  output logic                           avl_read,
  output logic                           avl_write,
  output logic [lsu_pkg::lane_count-1:0] avl_byte_en,
  output logic [lsu_pkg::data_width-1:0] avl_write_data,
  input  logic                           avl_request_ready,
  input  logic [lsu_pkg::data_width-1:0] avl_read_data,
  input  logic                           avl_read_data_valid
);

  // --------------------------------------------------
  // Held request and handshake wires
  // --------------------------------------------------
  logic [lsu_pkg::data_width-1:0] hold_addr;
  logic [lsu_pkg::data_width-1:0] hold_wdata;
  logic [lsu_pkg::op_width-1:0]   hold_op;
  logic                           cmd_read;
  logic                           cmd_write;
  logic                           start;
  logic                           split;
  logic                           cmd_done;
  logic                           load_done;
  logic [lsu_pkg::data_width-1:0] load_data;

  lsu_ctrl u_ctrl (
    .clk       (clk),
    .rest      (rest),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .req_write (req_write),
    .req_op    (req_op),
    .rsp_ready (rsp_ready),
    .cmd_done  (cmd_done),
    .load_done (load_done),
    .load_data (load_data),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata),
    .start     (start),
    .addr      (hold_addr),
    .wdata     (hold_wdata),
    .op        (hold_op),
    .read      (cmd_read),
    .write     (cmd_write)
  );

  lsu_cmd_split u_cmd_split (
    .clk               (clk),
    .rest              (rest),
    .addr              (hold_addr),
    .wdata             (hold_wdata),
    .op                (hold_op),
    .read              (cmd_read),
    .write             (cmd_write),
    .avl_request_ready (avl_request_ready),
    .split             (split),
    .cmd_done          (cmd_done),
    .avl_address       (avl_address),
    .avl_read          (avl_read),
    .avl_write         (avl_write),
    .avl_byte_en       (avl_byte_en),
    .avl_write_data    (avl_write_data)
  );

  lsu_rsp_merge u_rsp_merge (
    .clk                 (clk),
    .rest                (rest),
    .start               (start),
    .offset              (hold_addr[1:0]),
    .op                  (hold_op),
    .split               (split),
    .avl_read_data       (avl_read_data),
    .avl_read_data_valid (avl_read_data_valid),
    .load_done           (load_done),
    .load_data           (load_data)
  );

endmodule

`default_nettype wire

// ==== tb/lsu_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu_properties (
  input logic                           clk,
  input logic                           rest,
  input logic                           avl_read,
  input logic                           avl_write,
  input logic [lsu_pkg::data_width-1:0] avl_address,
  input logic [lsu_pkg::lane_count-1:0] avl_byte_en,
  input logic                           rsp_valid,
  input logic                           rsp_ready,
  input logic [lsu_pkg::data_width-1:0] rsp_rdata
);

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rest)
    !(avl_read && avl_write))
    else $error("avl_read and avl_write high together");

  a_word_aligned: assert property (@(posedge clk) disable iff (!rest)
    (avl_read || avl_write) |-> avl_address[1:0] == 2'b00)
    else $error("avl_address %h not word aligned", avl_address);

  a_write_lanes: assert property (@(posedge clk) disable iff (!rest)
    avl_write |-> avl_byte_en != '0)
    else $error("Write issued with no byte enable");

  // Response must not move before the pipeline takes it
  a_rsp_hold: assert property (@(posedge clk) disable iff (!rest)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
    else $error("rsp_valid or rsp_rdata changed while rsp_ready was low");

endmodule

bind lsu_top lsu_properties u_properties (
  .clk         (clk),
  .rest        (rest),
  .avl_read    (avl_read),
  .avl_write   (avl_write),
  .avl_address (avl_address),
  .avl_byte_en (avl_byte_en),
  .rsp_valid   (rsp_valid),
  .rsp_ready   (rsp_ready),
  .rsp_rdata   (rsp_rdata)
);

`default_nettype wire

// ==== tb/lsu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;

  localparam int n_entries      = 24;
  localparam int timeout_cycles = n_entries * 40;
  localparam int mem_words      = 16;

  typedef struct packed {
    logic                         is_write;
    logic [lsu_pkg::op_width-1:0] op;
    logic [31:0]                  addr;
    logic [31:0]                  wdata;
  } entry_t;

  logic                           clk                 = 1'b0;
  logic                           rest;
  logic                           req_valid;
  logic                           req_ready;
  logic [lsu_pkg::data_width-1:0] req_addr;
  logic [lsu_pkg::data_width-1:0] req_wdata;
  logic                           req_write;
  logic [lsu_pkg::op_width-1:0]   req_op;
  logic                           rsp_valid;
  logic                           rsp_ready           = 1'b0;
  logic [lsu_pkg::data_width-1:0] rsp_rdata;
  logic [lsu_pkg::data_width-1:0] avl_address;
  logic                           avl_read;
  logic                           avl_write;
  logic [lsu_pkg::lane_count-1:0] avl_byte_en;
  logic [lsu_pkg::data_width-1:0] avl_write_data;
  logic                           avl_request_ready   = 1'b0;
  logic [lsu_pkg::data_width-1:0] avl_read_data       = 32'h0;
  logic                           avl_read_data_valid = 1'b0;

  logic [31:0] rnd = 32'h277b1bdb;
  logic [31:0] mem    [mem_words];
  logic [31:0] shadow [mem_words];
  logic [31:0] rd_data_q [$];
  logic [1:0]  rd_lat_q  [$];
  logic [31:0] exp_rdata_q [$];
  logic [31:0] exp_addr_q  [$];
  int          exp_ncmd_q  [$];
  logic [31:0] cmd_seen    [$];
  int          errors    = 0;
  int          responses = 0;
  int          cycles    = 0;

  logic        stalled = 1'b0;
  logic [31:0] prev_address;
  logic        prev_read;
  logic        prev_write;
  logic [3:0]  prev_byte_en;
  logic [31:0] prev_write_data;

  // Stores first, then loads that read them back; signed values have the top bit set
  entry_t stim [n_entries] = '{
    '{1'b1, lsu_pkg::op_word,   32'h00, 32'h11223344},
    '{1'b1, lsu_pkg::op_word,   32'h04, 32'ha5b6c7d8},
    '{1'b0, lsu_pkg::op_word,   32'h00, 32'h0},
    '{1'b0, lsu_pkg::op_word,   32'h04, 32'h0},
    '{1'b1, lsu_pkg::op_byte,   32'h01, 32'h000000f0},
    '{1'b0, lsu_pkg::op_word,   32'h00, 32'h0},
    '{1'b0, lsu_pkg::op_byte,   32'h01, 32'h0},
    '{1'b0, lsu_pkg::op_byte_u, 32'h01, 32'h0},
    '{1'b1, lsu_pkg::op_half,   32'h06, 32'h0000beef},
    '{1'b0, lsu_pkg::op_word,   32'h04, 32'h0},
    '{1'b0, lsu_pkg::op_half,   32'h06, 32'h0},
    '{1'b0, lsu_pkg::op_half_u, 32'h06, 32'h0},
    '{1'b1, lsu_pkg::op_word,   32'h09, 32'hcafe8001},
    '{1'b0, lsu_pkg::op_word,   32'h09, 32'h0},
    '{1'b0, lsu_pkg::op_word,   32'h08, 32'h0},
    '{1'b0, lsu_pkg::op_word,   32'h0c, 32'h0},
    '{1'b1, lsu_pkg::op_half,   32'h13, 32'h00009abc},
    '{1'b0, lsu_pkg::op_half,   32'h13, 32'h0},
    '{1'b0, lsu_pkg::op_half_u, 32'h13, 32'h0},
    '{1'b1, lsu_pkg::op_word,   32'h1a, 32'h87654321},
    '{1'b0, lsu_pkg::op_word,   32'h1b, 32'h0},
    '{1'b0, lsu_pkg::op_byte,   32'h1c, 32'h0},
    '{1'b0, lsu_pkg::op_word,   32'h18, 32'h0},
    '{1'b0, lsu_pkg::op_byte_u, 32'h2f, 32'h0}
  };

  lsu_top u_dut (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] word_addr);
    return word_addr * 32'h9e3779b9 + 32'h2545f491;
  endfunction

  function automatic int access_len(input logic [2:0] op);
    case (op[1:0])
      2'd0:    return 1;
      2'd1:    return 2;
      default: return 4;
    endcase
  endfunction

  // Little endian byte walk over the shadow memory
  function automatic logic [31:0] expect_load(input logic [31:0] addr, input logic [2:0] op);
    logic [31:0] v;
    logic [31:0] a;
    int          len;
    int          k;
    v   = 32'h0;
    len = access_len(op);
    for (k = 0; k < len; k++) begin
      a = addr + k;
      v[8*k +: 8] = shadow[a[5:2]][8*a[1:0] +: 8];
    end
    if (len == 1 && !op[2]) v = {{24{v[7]}}, v[7:0]};
    if (len == 2 && !op[2]) v = {{16{v[15]}}, v[15:0]};
    return v;
  endfunction

  task automatic model_request(input int idx);
    logic [31:0] a;
    int          len;
    int          k;
    len = access_len(stim[idx].op);
    exp_ncmd_q.push_back((int'(stim[idx].addr[1:0]) + len > 4) ? 2 : 1);
    exp_addr_q.push_back({stim[idx].addr[31:2], 2'b00});
    if (stim[idx].is_write) begin
      for (k = 0; k < len; k++) begin
        a = stim[idx].addr + k;
        shadow[a[5:2]][8*a[1:0] +: 8] = stim[idx].wdata[8*k +: 8];
      end
      exp_rdata_q.push_back(32'h0);                 // Stores answer with zero
    end else begin
      exp_rdata_q.push_back(expect_load(stim[idx].addr, stim[idx].op));
    end
  endtask

  // --------------------------------------------------
  // Avalon memory model and random handshakes
  // --------------------------------------------------
  always @(posedge clk) begin : mem_model
    int w;
    int b;
    rnd = lcg_next(rnd);
    avl_request_ready   <= rnd[20:19] != 2'd0;      // Ready about three cycles in four
    rsp_ready           <= rnd[25:24] != 2'd0;
    avl_read_data_valid <= 1'b0;
    if (!rest) begin
      for (w = 0; w < mem_words; w++) mem[w] = fill_word(32'(w) << 2);
    end
    if (rd_lat_q.size() > 0) begin
      if (rd_lat_q[0] == 2'd0) begin
        avl_read_data_valid <= 1'b1;
        avl_read_data       <= rd_data_q.pop_front();
        void'(rd_lat_q.pop_front());
      end else begin
        rd_lat_q[0] = rd_lat_q[0] - 2'd1;
      end
    end
    if (avl_write && avl_request_ready) begin
      for (b = 0; b < lsu_pkg::lane_count; b++) begin
        if (avl_byte_en[b]) mem[avl_address[5:2]][8*b +: 8] = avl_write_data[8*b +: 8];
      end
    end
    if (avl_read && avl_request_ready) begin
      rd_data_q.push_back(mem[avl_address[5:2]]);
      rd_lat_q.push_back(rnd[29:28] % 2'd3);        // Returns in 1 to 3 cycles
    end
  end

  // --------------------------------------------------
  // Command and response checks
  // --------------------------------------------------
  always @(posedge clk) begin : monitor
    logic [31:0] exp_rdata;
    logic [31:0] exp_addr;
    int          exp_ncmd;
    if (rest) begin
      if (stalled) begin
        assert (avl_address == prev_address && avl_read == prev_read &&
                avl_write == prev_write && avl_byte_en == prev_byte_en &&
                avl_write_data == prev_write_data)
        else begin
          errors++;
          $display("Avalon command changed while avl_request_ready was low");
        end
      end
      stalled         = (avl_read || avl_write) && !avl_request_ready;
      prev_address    = avl_address;
      prev_read       = avl_read;
      prev_write      = avl_write;
      prev_byte_en    = avl_byte_en;
      prev_write_data = avl_write_data;
      if ((avl_read || avl_write) && avl_request_ready) cmd_seen.push_back(avl_address);
      if (rsp_valid && rsp_ready) begin
        assert (exp_rdata_q.size() > 0)
        else begin
          errors++;
          $display("Response arrived with no request outstanding");
        end
        if (exp_rdata_q.size() > 0) begin
          exp_rdata = exp_rdata_q.pop_front();
          exp_addr  = exp_addr_q.pop_front();
          exp_ncmd  = exp_ncmd_q.pop_front();
          assert (rsp_rdata == exp_rdata)
          else begin
            errors++;
            $display("[FAIL] rsp_rdata: got %h, expected %h (entry %0d)",
                     rsp_rdata, exp_rdata, responses);
          end
          assert (cmd_seen.size() == exp_ncmd)
          else begin
            errors++;
            $display("Entry %0d issued %0d Avalon commands instead of %0d",
                     responses, cmd_seen.size(), exp_ncmd);
          end
          if (cmd_seen.size() == exp_ncmd) begin
            assert (cmd_seen[0] == exp_addr)
            else begin
              errors++;
              $display("[FAIL] avl_address: got %h, expected %h", cmd_seen[0], exp_addr);
            end
            if (exp_ncmd == 2) begin
              assert (cmd_seen[1] == exp_addr + 32'd4)
              else begin
                errors++;
                $display("[FAIL] avl_address: got %h, expected %h",
                         cmd_seen[1], exp_addr + 32'd4);
              end
            end
          end
        end
        cmd_seen.delete();
        responses++;
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout after %0d cycles with %0d of %0d responses", cycles, responses, n_entries);
      $display("test failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin : stimulus
    int i;
    rest      = 1'b0;
    req_valid = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_write = 1'b0;
    req_op    = lsu_pkg::op_word;
    for (i = 0; i < mem_words; i++) shadow[i] = fill_word(32'(i) << 2);
    repeat (3) @(posedge clk);
    rest <= 1'b1;
    @(posedge clk);
    for (i = 0; i < n_entries; i++) begin
      req_valid <= 1'b1;
      req_write <= stim[i].is_write;
      req_op    <= stim[i].op;
      req_addr  <= stim[i].addr;
      req_wdata <= stim[i].wdata;
      @(posedge clk);
      while (!req_ready) @(posedge clk);             // Taken on this edge
      model_request(i);
    end
    req_valid <= 1'b0;
    while (responses < n_entries) @(posedge clk);
    repeat (2) @(posedge clk);
    $display("Errors: %0d, responses: %0d of %0d", errors, responses, n_entries);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/lsu_pkg.sv
verilog/lsu_cmd_split.sv
verilog/lsu_rsp_merge.sv
verilog/lsu_ctrl.sv
verilog/lsu_top.sv
tb/lsu_properties.sv
tb/lsu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = lsu_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
